//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_ddram
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST)) include/ddr_params.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/ddr_params.svh
`ifndef DDR_PARAMS_SVH
`define DDR_PARAMS_SVH

// DDR burst port
`define DDR_ADDR_W 29
`define DDR_DATA_W 64
`define DDR_BE_W 8
`define DDR_BURST_W 8

// client side 16-bit word addressing
`define CLI_ADDR_W 18

`define FB_LINE_BEATS 4
`define CDR_LINE_BEATS 2
`define FB_FIFO_ABITS 3
`define CDR_FIFO_ABITS 1

// region bases in 64-bit DDR words
`define FB_REGION 29'h6000000
`define CDR_REGION 29'h6010000

`endif

//--- logic/ddr_chan_if.sv
`default_nettype none

interface ddr_chan_if;

	// posted write at the FIFO head
	logic wr_pending;
	ddr_pkg::ddr_addr_t wr_addr;
	ddr_pkg::ddr_data_t wr_data;
	ddr_pkg::ddr_be_t wr_be;
	logic wr_pop;

	// line fetch
	logic rd_pending;
	ddr_pkg::ddr_addr_t rd_addr;
	logic fill_we;
	ddr_pkg::burst_t fill_beat;
	ddr_pkg::ddr_data_t fill_data;
	logic fill_done;

	modport client (
		output wr_pending, wr_addr, wr_data, wr_be, rd_pending, rd_addr,
		input wr_pop, fill_we, fill_beat, fill_data, fill_done
	);

	modport sequencer (
		input wr_pending, wr_addr, wr_data, wr_be, rd_pending, rd_addr,
		output wr_pop, fill_we, fill_beat, fill_data, fill_done
	);

endinterface

`default_nettype wire

//--- logic/ddr_client_port.sv
`default_nettype none

`include "ddr_params.svh"

module ddr_client_port #(
	parameter int LINE_BEATS = `FB_LINE_BEATS,
	parameter int FIFO_ABITS = `FB_FIFO_ABITS,
	parameter ddr_pkg::ddr_addr_t REGION = `FB_REGION
) (
	input wire CLK,
	input wire rst_pulse,
	input wire ddr_pkg::cli_addr_t addr,
	input wire ddr_pkg::cli_data_t din,
	input wire rd,
	input wire ddr_pkg::cli_be_t wr,
	output ddr_pkg::cli_data_t dout,
	output logic busy,
	ddr_chan_if.client chan
);

	localparam int BEAT_BITS = $clog2(LINE_BEATS);
	// four 16-bit words per beat
	localparam int LINE_LSB = BEAT_BITS + 2;
	localparam int PAYLOAD_W = $bits(ddr_pkg::cli_addr_t) + $bits(ddr_pkg::cli_be_t)
		+ $bits(ddr_pkg::cli_data_t);

	logic rd_old;
	logic wr_old;
	logic rd_edge;
	logic wr_edge;
	ddr_pkg::cli_addr_t tag_addr;
	logic dirty;
	logic read_busy;
	ddr_pkg::ddr_data_t line_ram [LINE_BEATS];
	ddr_pkg::ddr_data_t line_q;
	logic [PAYLOAD_W-1:0] fifo_dout;
	logic fifo_empty;
	logic fifo_full;
	ddr_pkg::cli_addr_t head_addr;
	ddr_pkg::cli_be_t head_be;
	ddr_pkg::cli_data_t head_data;

	assign rd_edge = rd && !rd_old;
	assign wr_edge = (|wr) && !wr_old;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			rd_old <= 1'b0;
			wr_old <= 1'b0;
			dirty <= 1'b1;
			read_busy <= 1'b0;
		end else begin
			rd_old <= rd;
			wr_old <= |wr;
			if (rd_edge) begin
				if (addr[`CLI_ADDR_W-1:LINE_LSB] != tag_addr[`CLI_ADDR_W-1:LINE_LSB] || dirty)
					read_busy <= 1'b1;
				dirty <= 1'b0;
			end
			// a write into the held line forces the next read to refetch
			if (wr_edge && addr[`CLI_ADDR_W-1:LINE_LSB] == tag_addr[`CLI_ADDR_W-1:LINE_LSB])
				dirty <= 1'b1;
			if (chan.fill_done)
				read_busy <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_edge)
			tag_addr <= addr;
	end

	ddr_write_fifo #(
		.ABITS(FIFO_ABITS),
		.WIDTH(PAYLOAD_W)
	) u_fifo (
		.CLK(CLK),
		.rst_pulse(rst_pulse),
		.din({addr, wr, din}),
		.push(wr_edge),
		.pop(chan.wr_pop),
		.dout(fifo_dout),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	assign {head_addr, head_be, head_data} = fifo_dout;

	always_ff @(posedge CLK) begin
		if (chan.fill_we)
			line_ram[chan.fill_beat[BEAT_BITS-1:0]] <= chan.fill_data;
	end

	// word 0 sits in the top lane
	always_comb begin
		line_q = line_ram[tag_addr[LINE_LSB-1:2]];
		case (tag_addr[1:0])
			2'd0: dout = line_q[63:48];
			2'd1: dout = line_q[47:32];
			2'd2: dout = line_q[31:16];
			default: dout = line_q[15:0];
		endcase
	end

	always_comb begin
		case (head_addr[1:0])
			2'd0: chan.wr_be = {head_be, 6'b000000};
			2'd1: chan.wr_be = {2'b00, head_be, 4'b0000};
			2'd2: chan.wr_be = {4'b0000, head_be, 2'b00};
			default: chan.wr_be = {6'b000000, head_be};
		endcase
	end

	assign chan.wr_pending = !fifo_empty;
	assign chan.wr_addr = REGION + ddr_pkg::ddr_addr_t'(head_addr[`CLI_ADDR_W-1:2]);
	assign chan.wr_data = {4{head_data}};
	assign chan.rd_pending = read_busy;
	assign chan.rd_addr = REGION
		+ (ddr_pkg::ddr_addr_t'(tag_addr[`CLI_ADDR_W-1:LINE_LSB]) << BEAT_BITS);

	assign busy = fifo_full | read_busy;

	// beats only land while this port waits on a fill
	a_fill_in_miss: assert property (@(posedge CLK) disable iff (rst_pulse)
		chan.fill_we |-> read_busy);

endmodule

`default_nettype wire

//--- logic/ddr_pkg.sv
`default_nettype none

`include "ddr_params.svh"

package ddr_pkg;

	typedef logic [`DDR_ADDR_W-1:0] ddr_addr_t;
	typedef logic [`DDR_DATA_W-1:0] ddr_data_t;
	typedef logic [`DDR_BE_W-1:0] ddr_be_t;
	typedef logic [`DDR_BURST_W-1:0] burst_t;

	typedef logic [`CLI_ADDR_W-1:0] cli_addr_t;
	typedef logic [15:0] cli_data_t;
	typedef logic [1:0] cli_be_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WRITE,
		SEQ_FILL
	} seq_state_t;

endpackage

`default_nettype wire

//--- logic/ddr_sequencer.sv
`default_nettype none

`include "ddr_params.svh"

module ddr_sequencer (
	input wire CLK,
	input wire rst_pulse,
	ddr_chan_if.sequencer fb,
	ddr_chan_if.sequencer cdr,
	input wire ddram_busy,
	input wire ddr_pkg::ddr_data_t ddram_dout,
	input wire ddram_dout_ready,
	output ddr_pkg::ddr_addr_t ddram_addr,
	output ddr_pkg::ddr_data_t ddram_din,
	output ddr_pkg::ddr_be_t ddram_be,
	output ddr_pkg::burst_t ddram_burstcnt,
	output logic ddram_rd,
	output logic ddram_we
);

	ddr_pkg::seq_state_t state;
	logic sel_cdr;
	ddr_pkg::burst_t beat_cnt;
	logic cmd_valid;
	logic cmd_read;
	logic cmd_cdr;
	logic issue;
	logic beat_ok;
	logic last_beat;

	// fb write, fb read, cdr write, cdr read
	always_comb begin
		cmd_valid = 1'b1;
		cmd_read = 1'b0;
		cmd_cdr = 1'b0;
		if (fb.wr_pending) begin
			cmd_read = 1'b0;
		end else if (fb.rd_pending) begin
			cmd_read = 1'b1;
		end else if (cdr.wr_pending) begin
			cmd_cdr = 1'b1;
		end else if (cdr.rd_pending) begin
			cmd_cdr = 1'b1;
			cmd_read = 1'b1;
		end else begin
			cmd_valid = 1'b0;
		end
	end

	assign issue = (state == ddr_pkg::SEQ_IDLE) && !ddram_busy && cmd_valid;
	assign beat_ok = (state == ddr_pkg::SEQ_FILL) && !ddram_busy && ddram_dout_ready;
	assign last_beat = beat_ok && (beat_cnt == ddram_burstcnt - ddr_pkg::burst_t'(1));

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			state <= ddr_pkg::SEQ_IDLE;
			ddram_rd <= 1'b0;
			ddram_we <= 1'b0;
		end else if (!ddram_busy) begin
			ddram_rd <= issue && cmd_read;
			ddram_we <= issue && !cmd_read;
			case (state)
				ddr_pkg::SEQ_IDLE: begin
					if (cmd_valid)
						state <= cmd_read ? ddr_pkg::SEQ_FILL : ddr_pkg::SEQ_WRITE;
				end
				ddr_pkg::SEQ_WRITE: state <= ddr_pkg::SEQ_IDLE;
				ddr_pkg::SEQ_FILL: begin
					if (last_beat)
						state <= ddr_pkg::SEQ_IDLE;
				end
				default: state <= ddr_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (issue) begin
			if (cmd_read)
				ddram_addr <= cmd_cdr ? cdr.rd_addr : fb.rd_addr;
			else
				ddram_addr <= cmd_cdr ? cdr.wr_addr : fb.wr_addr;
			ddram_din <= cmd_cdr ? cdr.wr_data : fb.wr_data;
			if (cmd_read)
				ddram_be <= '1;
			else
				ddram_be <= cmd_cdr ? cdr.wr_be : fb.wr_be;
			if (!cmd_read)
				ddram_burstcnt <= ddr_pkg::burst_t'(1);
			else if (cmd_cdr)
				ddram_burstcnt <= ddr_pkg::burst_t'(`CDR_LINE_BEATS);
			else
				ddram_burstcnt <= ddr_pkg::burst_t'(`FB_LINE_BEATS);
			sel_cdr <= cmd_cdr;
			beat_cnt <= '0;
		end else if (beat_ok) begin
			beat_cnt <= beat_cnt + ddr_pkg::burst_t'(1);
		end
	end

	assign fb.wr_pop = issue && !cmd_read && !cmd_cdr;
	assign cdr.wr_pop = issue && !cmd_read && cmd_cdr;

	assign fb.fill_we = beat_ok && !sel_cdr;
	assign fb.fill_beat = beat_cnt;
	assign fb.fill_data = ddram_dout;
	assign fb.fill_done = last_beat && !sel_cdr;

	assign cdr.fill_we = beat_ok && sel_cdr;
	assign cdr.fill_beat = beat_cnt;
	assign cdr.fill_data = ddram_dout;
	assign cdr.fill_done = last_beat && sel_cdr;

	a_rd_we_excl: assert property (@(posedge CLK) disable iff (rst_pulse)
		!(ddram_rd && ddram_we));

endmodule

`default_nettype wire

//--- logic/ddr_write_fifo.sv
`default_nettype none

`include "ddr_params.svh"

module ddr_write_fifo #(
	parameter int ABITS = `FB_FIFO_ABITS,
	parameter int WIDTH = $bits(ddr_pkg::cli_addr_t) + $bits(ddr_pkg::cli_be_t)
		+ $bits(ddr_pkg::cli_data_t)
) (
	input wire CLK,
	input wire rst_pulse,
	input wire [WIDTH-1:0] din,
	input wire push,
	input wire pop,
	output logic [WIDTH-1:0] dout,
	output logic empty,
	output logic full
);

	logic [WIDTH-1:0] mem [2**ABITS];
	logic [ABITS-1:0] wr_ptr;
	logic [ABITS-1:0] rd_ptr;
	logic [ABITS:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + ABITS'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + ABITS'(1);
			case ({do_push, do_pop})
				2'b10: count <= count + (ABITS+1)'(1);
				2'b01: count <= count - (ABITS+1)'(1);
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// head is visible without a read cycle
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = count[ABITS];

	// the client must hold off on busy
	a_no_push_full: assert property (@(posedge CLK) disable iff (rst_pulse) !(push && full));
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (rst_pulse) !(pop && empty));

endmodule

`default_nettype wire

//--- logic/ddram_top.sv
`default_nettype none

`include "ddr_params.svh"

module ddram_top (
	input wire CLK,
	input wire rst_pulse,

	input wire DDRAM_BUSY,
	output ddr_pkg::burst_t DDRAM_BURSTCNT,
	output ddr_pkg::ddr_addr_t DDRAM_ADDR,
	input wire ddr_pkg::ddr_data_t DDRAM_DOUT,
	input wire DDRAM_DOUT_READY,
	output logic DDRAM_RD,
	output ddr_pkg::ddr_data_t DDRAM_DIN,
	output ddr_pkg::ddr_be_t DDRAM_BE,
	output logic DDRAM_WE,

	input wire ddr_pkg::cli_addr_t fb_addr,
	input wire ddr_pkg::cli_data_t fb_din,
	output ddr_pkg::cli_data_t fb_dout,
	input wire fb_rd,
	input wire ddr_pkg::cli_be_t fb_wr,
	output logic fb_busy,

	input wire ddr_pkg::cli_addr_t cdr_addr,
	input wire ddr_pkg::cli_data_t cdr_din,
	output ddr_pkg::cli_data_t cdr_dout,
	input wire cdr_rd,
	input wire ddr_pkg::cli_be_t cdr_wr,
	output logic cdr_busy
);

	ddr_chan_if fb_chan ();
	ddr_chan_if cdr_chan ();

	ddr_client_port #(
		.LINE_BEATS(`FB_LINE_BEATS),
		.FIFO_ABITS(`FB_FIFO_ABITS),
		.REGION(`FB_REGION)
	) u_fb_port (
		.CLK(CLK),
		.rst_pulse(rst_pulse),
		.addr(fb_addr),
		.din(fb_din),
		.rd(fb_rd),
		.wr(fb_wr),
		.dout(fb_dout),
		.busy(fb_busy),
		.chan(fb_chan.client)
	);

	ddr_client_port #(
		.LINE_BEATS(`CDR_LINE_BEATS),
		.FIFO_ABITS(`CDR_FIFO_ABITS),
		.REGION(`CDR_REGION)
	) u_cdr_port (
		.CLK(CLK),
		.rst_pulse(rst_pulse),
		.addr(cdr_addr),
		.din(cdr_din),
		.rd(cdr_rd),
		.wr(cdr_wr),
		.dout(cdr_dout),
		.busy(cdr_busy),
		.chan(cdr_chan.client)
	);

	ddr_sequencer u_sequencer (
		.CLK(CLK),
		.rst_pulse(rst_pulse),
		.fb(fb_chan.sequencer),
		.cdr(cdr_chan.sequencer),
		.ddram_busy(DDRAM_BUSY),
		.ddram_dout(DDRAM_DOUT),
		.ddram_dout_ready(DDRAM_DOUT_READY),
		.ddram_addr(DDRAM_ADDR),
		.ddram_din(DDRAM_DIN),
		.ddram_be(DDRAM_BE),
		.ddram_burstcnt(DDRAM_BURSTCNT),
		.ddram_rd(DDRAM_RD),
		.ddram_we(DDRAM_WE)
	);

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
logic/ddr_pkg.sv
logic/ddr_chan_if.sv
logic/ddr_write_fifo.sv
logic/ddr_client_port.sv
logic/ddr_sequencer.sv
logic/ddram_top.sv
sim/ddr_mem_model.sv
sim/tb_ddram.sv

//--- sim/ddr_mem_model.sv
`default_nettype none

`include "ddr_params.svh"

module ddr_mem_model (
	input wire CLK,
	input wire rst_pulse,
	input wire ddr_pkg::ddr_addr_t ddram_addr,
	input wire ddr_pkg::burst_t ddram_burstcnt,
	input wire ddr_pkg::ddr_data_t ddram_din,
	input wire ddr_pkg::ddr_be_t ddram_be,
	input wire ddram_rd,
	input wire ddram_we,
	output logic ddram_busy,
	output ddr_pkg::ddr_data_t ddram_dout,
	output logic ddram_dout_ready,
	output int range_errors
);

	ddr_pkg::ddr_data_t mem [ddr_pkg::ddr_addr_t];
	logic [15:0] lfsr;
	ddr_pkg::ddr_addr_t burst_addr;
	int burst_left;
	int burst_idx;
	int lat;

	// 16-bit Galois LFSR with maximal length taps
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_step(lfsr);
		b = lfsr[0];
	endtask

	// unwritten words read back a pattern built from the whole address
	function automatic ddr_pkg::ddr_data_t read_word(input ddr_pkg::ddr_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {a, 3'b011, ~a, 3'b100};
	endfunction

	task automatic check_range(input ddr_pkg::ddr_addr_t a);
		if (!((a >= `FB_REGION && a < `FB_REGION + 29'h10000)
			|| (a >= `CDR_REGION && a < `CDR_REGION + 29'h10000))) begin
			$display("memory model: access to %h lies outside both client regions", a);
			range_errors++;
		end
	endtask

	initial begin
		ddram_busy = 1'b0;
		ddram_dout_ready = 1'b0;
		ddram_dout = '0;
		lfsr = 16'd55;
		burst_left = 0;
		burst_idx = 0;
		lat = 0;
		burst_addr = '0;
		range_errors = 0;
	end

	always @(posedge CLK) begin : step
		logic b0;
		logic b1;
		logic busy_n;
		logic ready_n;
		ddr_pkg::ddr_data_t w;
		if (rst_pulse) begin
			lfsr = 16'd55;
			burst_left = 0;
			#1;
			ddram_busy = 1'b0;
			ddram_dout_ready = 1'b0;
		end else begin
			// commands and beats count only in cycles without busy
			if (!ddram_busy && ddram_we) begin
				check_range(ddram_addr);
				w = read_word(ddram_addr);
				for (int i = 0; i < 8; i++)
					if (ddram_be[i])
						w[8*i +: 8] = ddram_din[8*i +: 8];
				mem[ddram_addr] = w;
			end
			if (!ddram_busy && ddram_rd) begin
				check_range(ddram_addr);
				check_range(ddram_addr + ddr_pkg::ddr_addr_t'(ddram_burstcnt)
					- ddr_pkg::ddr_addr_t'(1));
				burst_addr = ddram_addr;
				burst_left = int'(ddram_burstcnt);
				burst_idx = 0;
				take_bit(b0);
				take_bit(b1);
				lat = int'({b1, b0});
			end
			if (!ddram_busy && ddram_dout_ready) begin
				burst_idx++;
				burst_left--;
			end
			take_bit(b0);
			take_bit(b1);
			busy_n = b0 & b1;
			ready_n = 1'b0;
			if (burst_left > 0) begin
				if (lat > 0) begin
					lat--;
				end else begin
					take_bit(b0);
					take_bit(b1);
					ready_n = b0 | b1;
				end
			end
			#1;
			ddram_busy = busy_n;
			ddram_dout_ready = ready_n;
			ddram_dout = read_word(burst_addr + ddr_pkg::ddr_addr_t'(burst_idx));
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_ddram.sv
`default_nettype none

`include "ddr_params.svh"

module tb_ddram;

	localparam int WAIT_LIMIT = 400;

	logic CLK;
	logic rst_pulse;
	logic ddram_busy;
	ddr_pkg::burst_t ddram_burstcnt;
	ddr_pkg::ddr_addr_t ddram_addr;
	ddr_pkg::ddr_data_t ddram_dout;
	logic ddram_dout_ready;
	logic ddram_rd;
	ddr_pkg::ddr_data_t ddram_din;
	ddr_pkg::ddr_be_t ddram_be;
	logic ddram_we;
	ddr_pkg::cli_addr_t fb_addr;
	ddr_pkg::cli_data_t fb_din;
	ddr_pkg::cli_data_t fb_dout;
	logic fb_rd;
	ddr_pkg::cli_be_t fb_wr;
	logic fb_busy;
	ddr_pkg::cli_addr_t cdr_addr;
	ddr_pkg::cli_data_t cdr_din;
	ddr_pkg::cli_data_t cdr_dout;
	logic cdr_rd;
	ddr_pkg::cli_be_t cdr_wr;
	logic cdr_busy;
	int range_errors;

	int errors;
	int checks;
	// expected contents per client from the applied writes
	ddr_pkg::cli_data_t ref_fb [ddr_pkg::cli_addr_t];
	ddr_pkg::cli_data_t ref_cdr [ddr_pkg::cli_addr_t];

	ddram_top u_ddram_top (
		.CLK(CLK),
		.rst_pulse(rst_pulse),
		.DDRAM_BUSY(ddram_busy),
		.DDRAM_BURSTCNT(ddram_burstcnt),
		.DDRAM_ADDR(ddram_addr),
		.DDRAM_DOUT(ddram_dout),
		.DDRAM_DOUT_READY(ddram_dout_ready),
		.DDRAM_RD(ddram_rd),
		.DDRAM_DIN(ddram_din),
		.DDRAM_BE(ddram_be),
		.DDRAM_WE(ddram_we),
		.fb_addr(fb_addr),
		.fb_din(fb_din),
		.fb_dout(fb_dout),
		.fb_rd(fb_rd),
		.fb_wr(fb_wr),
		.fb_busy(fb_busy),
		.cdr_addr(cdr_addr),
		.cdr_din(cdr_din),
		.cdr_dout(cdr_dout),
		.cdr_rd(cdr_rd),
		.cdr_wr(cdr_wr),
		.cdr_busy(cdr_busy)
	);

	ddr_mem_model u_mem (
		.CLK(CLK),
		.rst_pulse(rst_pulse),
		.ddram_addr(ddram_addr),
		.ddram_burstcnt(ddram_burstcnt),
		.ddram_din(ddram_din),
		.ddram_be(ddram_be),
		.ddram_rd(ddram_rd),
		.ddram_we(ddram_we),
		.ddram_busy(ddram_busy),
		.ddram_dout(ddram_dout),
		.ddram_dout_ready(ddram_dout_ready),
		.range_errors(range_errors)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	task automatic report_mismatch(input string sig, input logic [15:0] got,
		input logic [15:0] exp);
		$display("FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic wait_idle(input logic is_cdr);
		int n;
		n = 0;
		while ((is_cdr ? cdr_busy : fb_busy) && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			$display("timeout at t=%0t, %s busy never fell", $time, is_cdr ? "cdr" : "fb");
			errors++;
		end
	endtask

	task automatic post_write(input logic is_cdr, input ddr_pkg::cli_addr_t a,
		input ddr_pkg::cli_data_t d, input ddr_pkg::cli_be_t be);
		ddr_pkg::cli_data_t v;
		wait_idle(is_cdr);
		v = 16'h0000;
		if (is_cdr && ref_cdr.exists(a))
			v = ref_cdr[a];
		if (!is_cdr && ref_fb.exists(a))
			v = ref_fb[a];
		if (be[1])
			v[15:8] = d[15:8];
		if (be[0])
			v[7:0] = d[7:0];
		if (is_cdr) begin
			ref_cdr[a] = v;
			cdr_addr = a;
			cdr_din = d;
			cdr_wr = be;
		end else begin
			ref_fb[a] = v;
			fb_addr = a;
			fb_din = d;
			fb_wr = be;
		end
		tick();
		fb_wr = 2'b00;
		cdr_wr = 2'b00;
		tick();
	endtask

	// a set expect_miss means the line must be fetched and busy rises after the edge
	task automatic read_check(input logic is_cdr, input ddr_pkg::cli_addr_t a,
		input logic expect_miss);
		ddr_pkg::cli_data_t got;
		ddr_pkg::cli_data_t exp;
		logic b;
		wait_idle(is_cdr);
		if (is_cdr) begin
			cdr_addr = a;
			cdr_rd = 1'b1;
		end else begin
			fb_addr = a;
			fb_rd = 1'b1;
		end
		tick();
		b = is_cdr ? cdr_busy : fb_busy;
		checks++;
		assert (b == expect_miss)
		else report_mismatch(is_cdr ? "cdr_busy" : "fb_busy", 16'(b), 16'(expect_miss));
		wait_idle(is_cdr);
		got = is_cdr ? cdr_dout : fb_dout;
		exp = is_cdr ? ref_cdr[a] : ref_fb[a];
		checks++;
		assert (got == exp)
		else report_mismatch(is_cdr ? "cdr_dout" : "fb_dout", got, exp);
		fb_rd = 1'b0;
		cdr_rd = 1'b0;
		tick();
	endtask

	task automatic write_then_read();
		for (int i = 0; i < 16; i++)
			post_write(1'b0, 18'h00100 + 18'(i), 16'hA000 + 16'(i * 257), 2'b11);
		read_check(1'b0, 18'h00105, 1'b1);
	endtask

	// each beat and each lane of the fetched line
	task automatic line_hit();
		read_check(1'b0, 18'h00100, 1'b0);
		read_check(1'b0, 18'h0010B, 1'b0);
		read_check(1'b0, 18'h0010F, 1'b0);
		read_check(1'b0, 18'h0010E, 1'b0);
		read_check(1'b0, 18'h00106, 1'b0);
	endtask

	task automatic invalidate_line();
		post_write(1'b0, 18'h0010A, 16'h5A5A, 2'b11);
		read_check(1'b0, 18'h0010A, 1'b1);
		read_check(1'b0, 18'h00103, 1'b0);
	endtask

	task automatic byte_merge();
		post_write(1'b0, 18'h00200, 16'h1234, 2'b11);
		post_write(1'b0, 18'h00200, 16'hABCD, 2'b01);
		post_write(1'b0, 18'h00200, 16'h5678, 2'b10);
		read_check(1'b0, 18'h00200, 1'b1);
	endtask

	task automatic region_split();
		post_write(1'b0, 18'h00040, 16'hF00D, 2'b11);
		post_write(1'b1, 18'h00040, 16'hCAFE, 2'b11);
		post_write(1'b0, 18'h00041, 16'h1111, 2'b11);
		post_write(1'b1, 18'h00041, 16'h2222, 2'b11);
		post_write(1'b1, 18'h00044, 16'h3333, 2'b11);
		read_check(1'b0, 18'h00040, 1'b1);
		read_check(1'b1, 18'h00040, 1'b1);
		read_check(1'b0, 18'h00041, 1'b0);
		read_check(1'b1, 18'h00041, 1'b0);
		// second beat of the cdr line
		read_check(1'b1, 18'h00044, 1'b0);
	endtask

	task automatic fifo_backpressure();
		for (int i = 0; i < 8; i++)
			post_write(1'b1, 18'h00300 + 18'(i), 16'h7000 + 16'(i), 2'b11);
		for (int i = 0; i < 4; i++)
			post_write(1'b1, 18'h00300 + 18'(i), 16'h8100 + 16'(i * 3), 2'b11);
		read_check(1'b1, 18'h00300, 1'b1);
		for (int i = 1; i < 8; i++)
			read_check(1'b1, 18'h00300 + 18'(i), 1'b0);
	endtask

	initial begin
		#5000000;
		$display("run did not finish within the time limit");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		checks = 0;
		rst_pulse = 1'b1;
		fb_addr = '0;
		fb_din = '0;
		fb_rd = 1'b0;
		fb_wr = 2'b00;
		cdr_addr = '0;
		cdr_din = '0;
		cdr_rd = 1'b0;
		cdr_wr = 2'b00;
		repeat (5) @(posedge CLK);
		#1;
		rst_pulse = 1'b0;
		tick();
		write_then_read();
		line_hit();
		invalidate_line();
		byte_merge();
		region_split();
		fifo_backpressure();
		checks++;
		assert (range_errors == 0)
		else begin
			$display("memory model saw accesses outside the client regions");
			errors++;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
